// ==== design/arbiter_defines.svh ====
// Vertex arbiter sizing macros for CU count, field widths and buffer depths
`ifndef ARBITER_DEFINES_SVH
`define ARBITER_DEFINES_SVH

// Compute unit row
`define NUM_CU 4
`define CU_ID_BITS 2

// Field widths
`define VERTEX_ID_BITS 32
`define ADDR_BITS 32
`define TAG_BITS 8

// Buffer depths
`define JOB_FIFO_DEPTH 8
`define CMD_FIFO_DEPTH 16

// Free entries left when almost-full rises, covers requests in flight
`define ALFULL_MARGIN 4

`endif

// ==== design/arbiter_pkg.sv ====
// Vertex arbiter payload types for jobs, read commands and read responses
`include "arbiter_defines.svh"

package arbiter_pkg;

	// Index of one vertex compute unit
	typedef logic [`CU_ID_BITS-1:0] cu_id_t;

	// One vertex job handed to a CU
	typedef struct packed {
		logic [`VERTEX_ID_BITS-1:0] vertex_id;
		logic [15:0]                degree;
	} vertex_job_t;

	// Read command toward the memory bus
	typedef struct packed {
		cu_id_t                cu_id;
		logic [`ADDR_BITS-1:0] address;
		logic [`TAG_BITS-1:0]  tag;
	} read_command_t;

	// Read response coming back from memory
	// cu_id names the CU that issued the matching command
	typedef struct packed {
		cu_id_t               cu_id;
		logic [`TAG_BITS-1:0] tag;
		logic [15:0]          data;
	} read_response_t;

endpackage

// ==== design/sync_fifo.sv ====
// Synchronous FIFO holding any payload type, with an almost-full flag
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module sync_fifo #(
	parameter type payload_t     = arbiter_pkg::vertex_job_t,
	parameter int  DEPTH         = `JOB_FIFO_DEPTH,
	parameter int  ALFULL_MARGIN = `ALFULL_MARGIN
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     empty,
	output logic     alfull
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Pushes into a full buffer and pops from an empty one are ignored
	assign do_push = push && (count != CNT_BITS'(DEPTH));
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head of the queue is always visible
	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign alfull   = (count >= CNT_BITS'(DEPTH - ALFULL_MARGIN));

endmodule

// ==== design/rr_arbiter.sv ====
// Round-robin arbiter giving a one-hot grant from a rotating priority pointer
`timescale 1ns/100ps

module rr_arbiter #(
	parameter int NUM_REQUESTS = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic [NUM_REQUESTS-1:0] requests,
	input  logic                    advance,
	output logic [NUM_REQUESTS-1:0] grant
);

	localparam int IDX_BITS = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [IDX_BITS-1:0] pointer;
	logic [IDX_BITS-1:0] grant_index;
	logic                found;

	// First requester at or after the pointer wins
	always_comb begin
		int unsigned idx;
		grant       = '0;
		grant_index = '0;
		found       = 1'b0;
		for (int k = 0; k < NUM_REQUESTS; k++) begin
			idx = (int'(pointer) + k) % NUM_REQUESTS;
			if (!found && requests[idx]) begin
				grant[idx]  = 1'b1;
				grant_index = IDX_BITS'(idx);
				found       = 1'b1;
			end
		end
	end

	// Winner drops to lowest priority once served
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer <= '0;
		end else if (advance && found) begin
			if (grant_index == IDX_BITS'(NUM_REQUESTS - 1)) begin
				pointer <= '0;
			end else begin
				pointer <= grant_index + 1'b1;
			end
		end
	end

endmodule

// ==== design/vertex_job_dispatch.sv ====
// Vertex job buffer with round-robin hand-out to CUs that asked for work
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module vertex_job_dispatch (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      vertex_job_valid,
	input  arbiter_pkg::vertex_job_t  vertex_job,
	output logic                      vertex_job_request,
	input  logic [`NUM_CU-1:0]        cu_job_request,
	output logic [`NUM_CU-1:0]        cu_job_valid,
	output arbiter_pkg::vertex_job_t  cu_job
);

	logic                     job_in_valid;
	arbiter_pkg::vertex_job_t job_in;
	arbiter_pkg::vertex_job_t job_head;
	logic                     job_empty;
	logic                     job_alfull;
	logic [`NUM_CU-1:0]       pending;
	logic [`NUM_CU-1:0]       grant;
	logic [`NUM_CU-1:0]       deliver;
	logic                     dispatch;

	//////////////////////////////////////////////////////////////////////
	// Job buffer
	//////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.payload_t    (arbiter_pkg::vertex_job_t),
		.DEPTH        (`JOB_FIFO_DEPTH),
		.ALFULL_MARGIN(`ALFULL_MARGIN)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_in_valid),
		.data_in (job_in),
		.pop     (dispatch),
		.data_out(job_head),
		.empty   (job_empty),
		.alfull  (job_alfull)
	);

	//////////////////////////////////////////////////////////////////////
	// Hand-out to pending CUs
	//////////////////////////////////////////////////////////////////////

	rr_arbiter #(
		.NUM_REQUESTS(`NUM_CU)
	) job_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.requests(pending),
		.advance (dispatch),
		.grant   (grant)
	);

	assign dispatch = !job_empty && (|pending);
	assign deliver  = {`NUM_CU{dispatch}} & grant;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_in_valid       <= 1'b0;
			vertex_job_request <= 1'b0;
			pending            <= '0;
			cu_job_valid       <= '0;
		end else begin
			job_in_valid       <= vertex_job_valid;
			vertex_job_request <= !job_alfull;
			// A CU pulses again only after delivery, so set and clear never meet
			pending            <= (pending & ~deliver) | cu_job_request;
			cu_job_valid       <= deliver;
		end
	end

	always_ff @(posedge clock) begin
		job_in <= vertex_job;
		if (dispatch) begin
			cu_job <= job_head;
		end
	end

endmodule

// ==== design/read_command_gather.sv ====
// Read command gathering from CU holding slots into a burst buffer for the bus
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module read_command_gather (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic [`NUM_CU-1:0]         cu_cmd_valid,
	input  arbiter_pkg::read_command_t cu_cmd [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]         cu_cmd_ready,
	input  logic                       read_buffer_alfull,
	input  logic                       read_command_bus_grant,
	output logic                       read_command_bus_request,
	output logic                       read_command_valid,
	output arbiter_pkg::read_command_t read_command
);

	arbiter_pkg::read_command_t slot_cmd [0:`NUM_CU-1];
	arbiter_pkg::read_command_t move_cmd;
	arbiter_pkg::read_command_t cmd_head;
	logic [`NUM_CU-1:0]         slot_valid;
	logic [`NUM_CU-1:0]         slot_next;
	logic [`NUM_CU-1:0]         move_grant;
	logic                       move;
	logic                       cmd_empty;
	logic                       cmd_alfull;
	logic                       alfull_latched;
	logic                       grant_latched;
	logic                       pop;

	//////////////////////////////////////////////////////////////////////
	// Holding slots and merge
	//////////////////////////////////////////////////////////////////////

	rr_arbiter #(
		.NUM_REQUESTS(`NUM_CU)
	) cmd_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.requests(slot_valid),
		.advance (move),
		.grant   (move_grant)
	);

	// Merging stops at almost-full, the slots absorb the rest
	assign move      = (|slot_valid) && !cmd_alfull;
	assign slot_next = (slot_valid & ~({`NUM_CU{move}} & move_grant)) | cu_cmd_valid;

	always_comb begin
		move_cmd = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			if (move_grant[i]) begin
				move_cmd = slot_cmd[i];
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `NUM_CU; i++) begin
			if (cu_cmd_valid[i]) begin
				slot_cmd[i] <= cu_cmd[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Burst buffer
	//////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.payload_t    (arbiter_pkg::read_command_t),
		.DEPTH        (`CMD_FIFO_DEPTH),
		.ALFULL_MARGIN(`ALFULL_MARGIN)
	) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (move),
		.data_in (move_cmd),
		.pop     (pop),
		.data_out(cmd_head),
		.empty   (cmd_empty),
		.alfull  (cmd_alfull)
	);

	//////////////////////////////////////////////////////////////////////
	// Bus request/grant
	//////////////////////////////////////////////////////////////////////

	assign pop = grant_latched && !cmd_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_valid               <= '0;
			cu_cmd_ready             <= '0;
			alfull_latched           <= 1'b0;
			grant_latched            <= 1'b0;
			read_command_bus_request <= 1'b0;
			read_command_valid       <= 1'b0;
		end else begin
			slot_valid               <= slot_next;
			cu_cmd_ready             <= ~slot_next & {`NUM_CU{!cmd_alfull}};
			alfull_latched           <= read_buffer_alfull;
			grant_latched            <= read_command_bus_grant;
			// Request held low until the granted pop has left the buffer
			read_command_bus_request <= !cmd_empty && !read_buffer_alfull && !alfull_latched
				&& !read_command_bus_grant && !grant_latched;
			read_command_valid       <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			read_command <= cmd_head;
		end
	end

endmodule

// ==== design/response_route.sv ====
// Routes each read response to the CU named by its cu_id, two cycles later
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module response_route (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        read_response_valid,
	input  arbiter_pkg::read_response_t read_response,
	output logic [`NUM_CU-1:0]          cu_response_valid,
	output arbiter_pkg::read_response_t cu_response
);

	logic                        resp_valid_q;
	arbiter_pkg::read_response_t resp_q;
	logic [`NUM_CU-1:0]          resp_decode;

	// cu_id to one-hot select
	assign resp_decode = {{(`NUM_CU-1){1'b0}}, resp_valid_q} << resp_q.cu_id;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_valid_q      <= 1'b0;
			cu_response_valid <= '0;
		end else begin
			resp_valid_q      <= read_response_valid;
			cu_response_valid <= resp_decode;
		end
	end

	// Payload rides alongside the valid
	always_ff @(posedge clock) begin
		resp_q      <= read_response;
		cu_response <= resp_q;
	end

endmodule

// ==== design/vertex_arbiter_control.sv ====
// Vertex arbiter top joining job dispatch, read command gathering and response routing
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module vertex_arbiter_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        vertex_job_valid,
	input  arbiter_pkg::vertex_job_t    vertex_job,
	output logic                        vertex_job_request,
	input  logic [`NUM_CU-1:0]          cu_job_request,
	output logic [`NUM_CU-1:0]          cu_job_valid,
	output arbiter_pkg::vertex_job_t    cu_job,
	input  logic [`NUM_CU-1:0]          cu_cmd_valid,
	input  arbiter_pkg::read_command_t  cu_cmd [0:`NUM_CU-1],
	output logic [`NUM_CU-1:0]          cu_cmd_ready,
	input  logic                        read_buffer_alfull,
	input  logic                        read_command_bus_grant,
	output logic                        read_command_bus_request,
	output logic                        read_command_valid,
	output arbiter_pkg::read_command_t  read_command,
	input  logic                        read_response_valid,
	input  arbiter_pkg::read_response_t read_response,
	output logic [`NUM_CU-1:0]          cu_response_valid,
	output arbiter_pkg::read_response_t cu_response
);

	//////////////////////////////////////////////////////////////////////
	// Vertex jobs
	//////////////////////////////////////////////////////////////////////

	vertex_job_dispatch job_dispatch (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_job_valid  (vertex_job_valid),
		.vertex_job        (vertex_job),
		.vertex_job_request(vertex_job_request),
		.cu_job_request    (cu_job_request),
		.cu_job_valid      (cu_job_valid),
		.cu_job            (cu_job)
	);

	//////////////////////////////////////////////////////////////////////
	// Read commands
	//////////////////////////////////////////////////////////////////////

	read_command_gather cmd_gather (
		.clock                   (clock),
		.rstn                    (rstn),
		.cu_cmd_valid            (cu_cmd_valid),
		.cu_cmd                  (cu_cmd),
		.cu_cmd_ready            (cu_cmd_ready),
		.read_buffer_alfull      (read_buffer_alfull),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command            (read_command)
	);

	// Responses, fixed two-cycle path
	response_route resp_route (
		.clock              (clock),
		.rstn               (rstn),
		.read_response_valid(read_response_valid),
		.read_response      (read_response),
		.cu_response_valid  (cu_response_valid),
		.cu_response        (cu_response)
	);

endmodule

// ==== test/vertex_arbiter_properties.sv ====
// Bound checks on bus grant timing, almost-full blocking and job hand-out
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module vertex_arbiter_properties (
	input logic               clock,
	input logic               rstn,
	input logic               read_buffer_alfull,
	input logic               read_command_bus_grant,
	input logic               read_command_bus_request,
	input logic               read_command_valid,
	input logic [`NUM_CU-1:0] cu_job_valid
);

	// Registered almost-full keeps the request low
	request_blocked: assert property (@(posedge clock) disable iff (!rstn)
		$past(read_buffer_alfull) |-> !read_command_bus_request)
		else $error("read command bus request raised while the read buffer was almost full");

	// Command leaves exactly two cycles after its grant
	grant_to_valid: assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid == $past(read_command_bus_grant, 2))
		else $error("read_command_valid not two cycles after read_command_bus_grant");

	// One CU served per cycle
	single_job: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_job_valid))
		else $error("more than one cu_job_valid bit set in one cycle");

endmodule

bind vertex_arbiter_control vertex_arbiter_properties props (
	.clock                   (clock),
	.rstn                    (rstn),
	.read_buffer_alfull      (read_buffer_alfull),
	.read_command_bus_grant  (read_command_bus_grant),
	.read_command_bus_request(read_command_bus_request),
	.read_command_valid      (read_command_valid),
	.cu_job_valid            (cu_job_valid)
);

// ==== test/tb_vertex_arbiter.sv ====
// Vertex arbiter testbench with LFSR stimulus checked against a queue-based model
`timescale 1ns/100ps
`include "arbiter_defines.svh"

module tb_vertex_arbiter;

	localparam int NUM_JOBS    = 160;
	localparam int CMDS_PER_CU = 40;
	localparam int CYCLE_LIMIT = 4000;

	logic                        clock;
	logic                        rstn;
	logic                        vertex_job_valid;
	arbiter_pkg::vertex_job_t    vertex_job;
	logic                        vertex_job_request;
	logic [`NUM_CU-1:0]          cu_job_request;
	logic [`NUM_CU-1:0]          cu_job_valid;
	arbiter_pkg::vertex_job_t    cu_job;
	logic [`NUM_CU-1:0]          cu_cmd_valid;
	arbiter_pkg::read_command_t  cu_cmd [0:`NUM_CU-1];
	logic [`NUM_CU-1:0]          cu_cmd_ready;
	logic                        read_buffer_alfull;
	logic                        read_command_bus_grant;
	logic                        read_command_bus_request;
	logic                        read_command_valid;
	arbiter_pkg::read_command_t  read_command;
	logic                        read_response_valid;
	arbiter_pkg::read_response_t read_response;
	logic [`NUM_CU-1:0]          cu_response_valid;
	arbiter_pkg::read_response_t cu_response;

	// Reference model state
	logic [31:0]                 lfsr_state;
	int                          cycle_count;
	int                          mismatch_count;
	int                          failure_count;
	arbiter_pkg::vertex_job_t    job_queue [$];
	arbiter_pkg::read_command_t  cmd_queue [`NUM_CU][$];
	arbiter_pkg::read_response_t resp_queue [$];
	int                          resp_due [$];
	int                          cu_id_log [$];
	logic [`NUM_CU-1:0]          job_waiting;
	int                          jobs_pushed;
	int                          jobs_asked;
	int                          cmds_sent [`NUM_CU];
	logic                        ask_on;
	logic                        traffic_on;
	logic                        burst_fire;
	logic                        refill_on;
	logic                        saw_job_request_low;
	logic                        grant_open;
	int                          grant_age;
	int                          alfull_hold;

	vertex_arbiter_control dut (.*);

	always #2 clock = ~clock;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < count; k++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hD000_0001 : 32'h0);
		end
		return value;
	endfunction

	function automatic logic commands_drained();
		logic done;
		done = !grant_open;
		for (int i = 0; i < `NUM_CU; i++) begin
			if (cmds_sent[i] < CMDS_PER_CU || cmd_queue[i].size() > 0)
				done = 1'b0;
		end
		return done;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Output checks once per cycle
	//////////////////////////////////////////////////////////////////////

	task automatic check_outputs();
		logic [`NUM_CU-1:0] expect_valid;
		if (!vertex_job_request)
			saw_job_request_low = 1'b1;
		assert ($onehot0(cu_job_valid)) else begin
			failure_count++;
			$display("Several CUs got a job in one cycle at %0t", $time);
		end
		for (int i = 0; i < `NUM_CU; i++) begin
			if (cu_job_valid[i]) begin
				assert (job_waiting[i] && job_queue.size() > 0) else begin
					failure_count++;
					$display("CU %0d got a job it never asked for at %0t", i, $time);
				end
				if (job_queue.size() > 0) begin
					assert (cu_job == job_queue[0]) else begin
						mismatch_count++;
						$display("Mismatch at %0t: CU %0d job %h, expected %h",
							$time, i, cu_job, job_queue[0]);
					end
					void'(job_queue.pop_front());
				end
				job_waiting[i] = 1'b0;
			end
		end
		// Almost-full seen at the last edge blocks the bus side
		if (read_buffer_alfull) begin
			assert (!read_command_bus_request && !read_command_valid) else begin
				failure_count++;
				$display("Bus request or command while read buffer almost full at %0t", $time);
			end
		end
		if (grant_open)
			grant_age++;
		if (read_command_valid) begin
			assert (grant_open && grant_age == 2) else begin
				failure_count++;
				$display("Read command at %0t not issued two cycles after a grant", $time);
			end
			grant_open = 1'b0;
			cu_id_log.push_back(int'(read_command.cu_id));
			assert (cmd_queue[read_command.cu_id].size() > 0) else begin
				failure_count++;
				$display("Read command for CU %0d never accepted, at %0t",
					read_command.cu_id, $time);
			end
			if (cmd_queue[read_command.cu_id].size() > 0) begin
				assert (read_command == cmd_queue[read_command.cu_id][0]) else begin
					mismatch_count++;
					$display("Mismatch at %0t: read command %h, expected %h",
						$time, read_command, cmd_queue[read_command.cu_id][0]);
				end
				void'(cmd_queue[read_command.cu_id].pop_front());
			end
		end
		expect_valid = '0;
		if (resp_due.size() > 0 && resp_due[0] == cycle_count) begin
			expect_valid[resp_queue[0].cu_id] = 1'b1;
			assert (cu_response == resp_queue[0]) else begin
				mismatch_count++;
				$display("Mismatch at %0t: response %h, expected %h",
					$time, cu_response, resp_queue[0]);
			end
			void'(resp_due.pop_front());
			void'(resp_queue.pop_front());
		end
		assert (cu_response_valid == expect_valid) else begin
			mismatch_count++;
			$display("Mismatch at %0t: cu_response_valid %b, expected %b",
				$time, cu_response_valid, expect_valid);
		end
	endtask

	task automatic send_command(input int i);
		cu_cmd_valid[i] = 1'b1;
		cu_cmd[i]       = {arbiter_pkg::cu_id_t'(i), take_bits(32), 8'(cmds_sent[i])};
		cmd_queue[i].push_back(cu_cmd[i]);
		cmds_sent[i]++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus driven 1 ns after the rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic drive_inputs();
		vertex_job_valid       = 1'b0;
		cu_job_request         = '0;
		cu_cmd_valid           = '0;
		read_command_bus_grant = 1'b0;
		read_response_valid    = 1'b0;
		// Full rate until CUs start asking, so the job buffer backs up
		if (vertex_job_request && jobs_pushed < NUM_JOBS && (!ask_on || take_bits(1) != 0)) begin
			vertex_job_valid = 1'b1;
			vertex_job       = {take_bits(32), 16'(take_bits(16))};
			job_queue.push_back(vertex_job);
			jobs_pushed++;
		end
		for (int i = 0; i < `NUM_CU; i++) begin
			if (ask_on && !job_waiting[i] && jobs_asked < NUM_JOBS && take_bits(2) == 0) begin
				cu_job_request[i] = 1'b1;
				job_waiting[i]    = 1'b1;
				jobs_asked++;
			end
			if (traffic_on && cu_cmd_ready[i] && cmds_sent[i] < CMDS_PER_CU
				&& take_bits(1) != 0)
				send_command(i);
			// A freed slot is reloaded at once so its CU competes again
			else if (refill_on && cu_cmd_ready[i])
				send_command(i);
		end
		if (burst_fire && cu_cmd_ready == '1) begin
			for (int i = 0; i < `NUM_CU; i++)
				send_command(i);
			burst_fire = 1'b0;
			refill_on  = 1'b1;
		end
		// Almost-full only raised with no grant outstanding
		if (alfull_hold > 0) begin
			alfull_hold--;
		end else begin
			read_buffer_alfull = 1'b0;
			if (!grant_open && take_bits(4) == 0) begin
				read_buffer_alfull = 1'b1;
				alfull_hold        = 3 + int'(take_bits(3));
			end
		end
		if (!read_buffer_alfull && read_command_bus_request && !grant_open
			&& take_bits(1) != 0) begin
			read_command_bus_grant = 1'b1;
			grant_open             = 1'b1;
			grant_age              = 0;
		end
		if (traffic_on && take_bits(1) != 0) begin
			read_response_valid = 1'b1;
			read_response       = 26'(take_bits(26));
			resp_queue.push_back(read_response);
			resp_due.push_back(cycle_count + 2);
		end
	endtask

	task automatic run_cycle();
		@(posedge clock);
		#1;
		cycle_count++;
		check_outputs();
		drive_inputs();
	endtask

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles, traffic never drained", cycle_count);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [`NUM_CU-1:0] cu_mask;
		clock                  = 1'b0;
		rstn                   = 1'b0;
		vertex_job_valid       = 1'b0;
		vertex_job             = '0;
		cu_job_request         = '0;
		cu_cmd_valid           = '0;
		read_buffer_alfull     = 1'b0;
		read_command_bus_grant = 1'b0;
		read_response_valid    = 1'b0;
		read_response          = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			cu_cmd[i]    = '0;
			cmds_sent[i] = 0;
		end
		lfsr_state          = 32'h6915427d;
		job_waiting         = '0;
		ask_on              = 1'b0;
		traffic_on          = 1'b1;
		burst_fire          = 1'b0;
		refill_on           = 1'b0;
		saw_job_request_low = 1'b0;
		grant_open          = 1'b0;
		alfull_hold         = 0;
		repeat (8) @(posedge clock);
		assert (vertex_job_request == 1'b0 && cu_job_valid == '0 && cu_cmd_ready == '0
			&& !read_command_bus_request && !read_command_valid && cu_response_valid == '0)
		else begin
			failure_count++;
			$display("Control outputs not inactive during reset");
		end
		#1;
		rstn = 1'b1;
		// Jobs pile up with no CU asking
		repeat (40) run_cycle();
		assert (saw_job_request_low) else begin
			failure_count++;
			$display("vertex_job_request never fell while jobs piled up");
		end
		ask_on = 1'b1;
		while (jobs_asked < NUM_JOBS || job_waiting != '0 || !commands_drained())
			run_cycle();
		traffic_on = 1'b0;
		while (resp_due.size() > 0)
			run_cycle();
		assert (job_queue.size() == 0 && jobs_pushed == NUM_JOBS) else begin
			failure_count++;
			$display("%0d pushed jobs never reached a CU", job_queue.size());
		end
		// All four slots loaded at once and refilled as they free up
		for (int round = 0; round < 6; round++) begin
			cu_id_log.delete();
			burst_fire = 1'b1;
			while (cu_id_log.size() < `NUM_CU)
				run_cycle();
			refill_on = 1'b0;
			cu_mask   = '0;
			foreach (cu_id_log[k])
				cu_mask[cu_id_log[k]] = 1'b1;
			assert (cu_mask == '1) else begin
				failure_count++;
				$display("Burst round %0d was not served by four different CUs", round);
			end
			while (!commands_drained())
				run_cycle();
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+design
design/arbiter_pkg.sv
design/sync_fifo.sv
design/rr_arbiter.sv
design/vertex_job_dispatch.sv
design/read_command_gather.sv
design/response_route.sv
design/vertex_arbiter_control.sv
test/vertex_arbiter_properties.sv
test/tb_vertex_arbiter.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vertex arbiter testbench with Verilator
verilator --binary --timing --assert -f compile.f --top-module tb_vertex_arbiter \
	-o tb_vertex_arbiter > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_vertex_arbiter +verilator+error+limit+100 > sim.log 2>&1 \
	|| echo "Simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Simulator exited with an error status" sim.log && exit 1 || exit 0
